// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - verilog/soc_map_pkg.sv
  - verilog/bus_pkg.sv
  - verilog/bus_decode.sv
  - verilog/ram_device.sv
  - verilog/gpio_device.sv
  - verilog/mtimer_device.sv
  - verilog/bus_result.sv
  - verilog/soc_bus_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_soc_bus.sv

// ==== sim.f ====
verilog/soc_map_pkg.sv
verilog/bus_pkg.sv
verilog/bus_decode.sv
verilog/ram_device.sv
verilog/gpio_device.sv
verilog/mtimer_device.sv
verilog/bus_result.sv
verilog/soc_bus_top.sv
tb/tb_clock_gen.sv
tb/tb_soc_bus.sv

// ==== tb/tb_clock_gen.sv ====
/*
  Clock and reset source for the testbench.
  Makes a 20 ns clock and holds reset high for the first
  reset_cycles rising edges.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned reset_cycles = 16
) (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #10 clock_o = ~clock_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_soc_bus.sv ====
/*
  Directed testbench for the system bus.
  Acts as the bus manager: drives read and write pulses on the request
  port and checks RAM, response timing, GPIO and the machine timer
  against values worked out from the register map. Prints one line per
  test and a closing line with the counts.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

  localparam int unsigned memory_size = 8192;
  localparam int unsigned gpio_width  = 8;
  // About 400 cycles of tests after reset, so this leaves a wide margin
  localparam int unsigned timeout_cycles = 4000;
  localparam int unsigned max_latency    = 4;

  localparam logic [31:0] unmapped_addr  = 32'h4000_0000;
  localparam logic [31:0] timer_control  = soc_map_pkg::mtimer_base + 32'd0;
  localparam logic [31:0] timer_mtime_lo = soc_map_pkg::mtimer_base + 32'd4;
  localparam logic [31:0] timer_mtime_hi = soc_map_pkg::mtimer_base + 32'd8;
  localparam logic [31:0] timer_cmp_lo   = soc_map_pkg::mtimer_base + 32'd12;
  localparam logic [31:0] timer_cmp_hi   = soc_map_pkg::mtimer_base + 32'd16;
  localparam logic [31:0] gpio_in_addr   = soc_map_pkg::gpio_base + 32'd0;
  localparam logic [31:0] gpio_oe_addr   = soc_map_pkg::gpio_base + 32'd4;
  localparam logic [31:0] gpio_out_addr  = soc_map_pkg::gpio_base + 32'd8;
  localparam logic [31:0] gpio_set_addr  = soc_map_pkg::gpio_base + 32'd12;
  localparam logic [31:0] gpio_clr_addr  = soc_map_pkg::gpio_base + 32'd16;

  logic                  clock;
  logic                  reset;
  bus_pkg::bus_req_t     bus_req;
  bus_pkg::bus_rsp_t     bus_rsp;
  logic [gpio_width-1:0] gpio_input;
  logic [gpio_width-1:0] gpio_oe;
  logic [gpio_width-1:0] gpio_output;
  logic                  irq_timer;

  int     errors       = 0;
  int     failed_tests = 0;
  int     cycle_count  = 0;
  integer seed;

  tb_clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  soc_bus_top #(
    .memory_size (memory_size),
    .gpio_width  (gpio_width)
  ) DUT (
    .clock         (clock),
    .reset         (reset),
    .bus_req_i     (bus_req),
    .bus_rsp_o     (bus_rsp),
    .gpio_input_i  (gpio_input),
    .gpio_oe_o     (gpio_oe),
    .gpio_output_o (gpio_output),
    .irq_timer_o   (irq_timer)
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Reporting
  // --------------------------------------------------------------------------

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    $display("error: %s is 0x%08h, expected 0x%08h", name, got, expected);
    errors++;
  endtask

  task automatic plain_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      failed_tests++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus manager
  // --------------------------------------------------------------------------

  function automatic logic response_seen(input logic is_write);
    return is_write ? bus_rsp.write_response : bus_rsp.read_response;
  endfunction

  // One pulse, then the response must show up exactly one cycle later
  task automatic single_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strobe, input logic is_write,
                               output logic [31:0] rdata);
    int latency;
    @(posedge clock);
    bus_req.address       <= addr;
    bus_req.write_data    <= wdata;
    bus_req.write_strobe  <= strobe;
    bus_req.read_request  <= !is_write;
    bus_req.write_request <= is_write;
    @(negedge clock);
    if (response_seen(is_write)) begin
      plain_error($sformatf("response came in the request cycle at 0x%08h", addr));
    end
    @(posedge clock);
    bus_req.read_request  <= 1'b0;
    bus_req.write_request <= 1'b0;
    latency = 1;
    @(negedge clock);
    while (!response_seen(is_write) && latency < max_latency) begin
      @(negedge clock);
      latency++;
    end
    if (!response_seen(is_write)) begin
      plain_error($sformatf("no response within %0d cycles at 0x%08h", latency, addr));
    end else if (latency != 1) begin
      plain_error($sformatf("response took %0d cycles at 0x%08h", latency, addr));
    end
    if (response_seen(!is_write)) begin
      plain_error($sformatf("wrong kind of response flag at 0x%08h", addr));
    end
    rdata = bus_rsp.read_data;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strobe);
    logic [31:0] unused;
    single_access(addr, wdata, strobe, 1'b1, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    single_access(addr, 32'h0, 4'h0, 1'b0, rdata);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic ram_readback();
    logic [31:0] addrs [16];
    logic [31:0] words [16];
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] expected;
    logic        dup;
    int          i;
    int          j;
    int          errors_before;
    errors_before = errors;
    // Distinct word addresses so no write hides another
    for (i = 0; i < 16; i++) begin
      do begin
        addr = $random(seed) & (memory_size - 4);
        dup  = 1'b0;
        for (j = 0; j < i; j++) begin
          if (addrs[j] == addr) begin
            dup = 1'b1;
          end
        end
      end while (dup);
      addrs[i] = addr;
      words[i] = $random(seed);
      bus_write(addr, words[i], 4'hf);
    end
    for (i = 0; i < 16; i++) begin
      bus_read(addrs[i], rdata);
      if (rdata !== words[i]) begin
        value_error($sformatf("ram[0x%04h]", addrs[i]), rdata, words[i]);
      end
    end
    addr     = memory_size - 4;
    old_word = $random(seed);
    new_word = $random(seed);
    bus_write(addr, old_word, 4'hf);
    bus_write(addr, new_word, 4'b0101);
    expected = {old_word[31:24], new_word[23:16], old_word[15:8], new_word[7:0]};
    bus_read(addr, rdata);
    if (rdata !== expected) begin
      value_error("ram strobed word", rdata, expected);
    end
    close_test("ram", errors_before);
  endtask

  task automatic response_timing();
    logic [31:0] rdata;
    int          errors_before;
    errors_before = errors;
    bus_write(soc_map_pkg::ram_base + 32'h40, 32'h5a5a_0f0f, 4'hf);
    bus_read(soc_map_pkg::ram_base + 32'h40, rdata);
    if (rdata !== 32'h5a5a_0f0f) begin
      value_error("ram read data", rdata, 32'h5a5a_0f0f);
    end
    bus_write(timer_cmp_hi, 32'hffff_ffff, 4'hf);
    bus_read(timer_control, rdata);
    if (rdata !== 32'h0) begin
      value_error("timer control", rdata, 32'h0);
    end
    bus_write(gpio_oe_addr, 32'h0000_005a, 4'hf);
    bus_read(gpio_oe_addr, rdata);
    if (rdata !== 32'h0000_005a) begin
      value_error("gpio oe", rdata, 32'h0000_005a);
    end
    // Unmapped accesses, including a word past the GPIO region that
    // lines up with the output-enable offset
    bus_write(unmapped_addr, 32'hdead_beef, 4'hf);
    bus_read(unmapped_addr, rdata);
    if (rdata !== 32'h0) begin
      value_error("unmapped read data", rdata, 32'h0);
    end
    bus_read(soc_map_pkg::gpio_base + 32'd36, rdata);
    if (rdata !== 32'h0) begin
      value_error("read past gpio", rdata, 32'h0);
    end
    close_test("response timing", errors_before);
  endtask

  task automatic gpio_registers();
    logic [31:0]           rdata;
    logic [gpio_width-1:0] expected_out;
    int                    errors_before;
    errors_before = errors;
    bus_write(gpio_oe_addr, 32'h0000_00a5, 4'hf);
    if (gpio_oe !== 8'ha5) begin
      value_error("gpio_oe_o", gpio_oe, 32'ha5);
    end
    expected_out = 8'h3c;
    bus_write(gpio_out_addr, expected_out, 4'hf);
    if (gpio_output !== expected_out) begin
      value_error("gpio_output_o", gpio_output, expected_out);
    end
    expected_out = expected_out | 8'h41;
    bus_write(gpio_set_addr, 32'h0000_0041, 4'hf);
    if (gpio_output !== expected_out) begin
      value_error("gpio_output_o after set", gpio_output, expected_out);
    end
    expected_out = expected_out & ~8'h0c;
    bus_write(gpio_clr_addr, 32'h0000_000c, 4'hf);
    if (gpio_output !== expected_out) begin
      value_error("gpio_output_o after clear", gpio_output, expected_out);
    end
    bus_read(gpio_out_addr, rdata);
    if (rdata !== {24'h0, expected_out}) begin
      value_error("gpio output register", rdata, expected_out);
    end
    bus_read(gpio_set_addr, rdata);
    if (rdata !== 32'h0) begin
      value_error("gpio set register", rdata, 32'h0);
    end
    // Two synchronizer stages, plus one spare cycle
    @(posedge clock);
    gpio_input <= 8'h96;
    repeat (3) @(posedge clock);
    bus_read(gpio_in_addr, rdata);
    if (rdata !== 32'h96) begin
      value_error("gpio input register", rdata, 32'h96);
    end
    close_test("gpio", errors_before);
  endtask

  task automatic timer_compare();
    int errors_before;
    errors_before = errors;
    bus_write(timer_control, 32'h0, 4'hf);
    bus_write(timer_cmp_hi, 32'h0, 4'hf);
    bus_write(timer_cmp_lo, 32'd100, 4'hf);
    bus_write(timer_mtime_hi, 32'h0, 4'hf);
    bus_write(timer_mtime_lo, 32'h0, 4'hf);
    bus_write(timer_control, 32'h1, 4'hf);
    if (irq_timer !== 1'b0) begin
      value_error("irq_timer_o at enable", irq_timer, 32'h0);
    end
    repeat (10) @(posedge clock);
    @(negedge clock);
    if (irq_timer !== 1'b0) begin
      value_error("irq_timer_o early", irq_timer, 32'h0);
    end
    repeat (150) @(posedge clock);
    @(negedge clock);
    if (irq_timer !== 1'b1) begin
      value_error("irq_timer_o after compare", irq_timer, 32'h1);
    end
    bus_write(timer_cmp_lo, 32'hffff_ffff, 4'hf);
    bus_write(timer_cmp_hi, 32'hffff_ffff, 4'hf);
    @(posedge clock);
    @(negedge clock);
    if (irq_timer !== 1'b0) begin
      value_error("irq_timer_o after raise", irq_timer, 32'h0);
    end
    bus_write(timer_control, 32'h0, 4'hf);
    close_test("timer compare", errors_before);
  endtask

  task automatic timer_counting();
    logic [31:0] rdata;
    int          errors_before;
    errors_before = errors;
    bus_write(timer_control, 32'h0, 4'hf);
    bus_write(timer_mtime_lo, 32'hffff_fff0, 4'hf);
    bus_write(timer_mtime_hi, 32'h0, 4'hf);
    bus_write(timer_control, 32'h1, 4'hf);
    repeat (40) @(posedge clock);
    // Low word has wrapped, so the carry shows in the high word
    bus_read(timer_mtime_hi, rdata);
    if (rdata !== 32'h1) begin
      value_error("mtime high word", rdata, 32'h1);
    end
    bus_read(timer_mtime_lo, rdata);
    if ($isunknown(rdata) || rdata == 32'h0 || rdata > 32'd40) begin
      plain_error($sformatf("error: mtime low word 0x%08h is not in 0x1 to 0x28", rdata));
    end
    bus_write(timer_control, 32'h0, 4'hf);
    close_test("timer counting", errors_before);
  endtask

  // --------------------------------------------------------------------------
  // Run
  // --------------------------------------------------------------------------

  initial begin
    bus_req    = '0;
    gpio_input = '0;
    seed       = 32'hd6da;
    @(negedge reset);
    ram_readback();
    response_timing();
    gpio_registers();
    timer_compare();
    timer_counting();
    $display("tests: 5, failed tests: %0d, errors: %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/bus_decode.sv ====
/*
  Decode stage of a bus transaction.
  Matches the manager address against each device region and hands
  every device its own request with the offset inside its region.
  The device requests are combinational; the route record is
  registered so the result stage can steer the response a cycle later.
*/

`timescale 1ns/1ps
`default_nettype none

module bus_decode #(
  parameter int unsigned memory_size = 8192
) (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::bus_req_t  bus_req_i,
  output bus_pkg::dev_req_t       ram_req_o,
  output bus_pkg::dev_req_t       mtimer_req_o,
  output bus_pkg::dev_req_t       gpio_req_o,
  output bus_pkg::bus_route_t     route_o
);

  logic [31:0] ram_offset;
  logic [31:0] mtimer_offset;
  logic [31:0] gpio_offset;
  logic        ram_hit;
  logic        mtimer_hit;
  logic        gpio_hit;
  logic        any_hit;
  soc_map_pkg::dev_index_t hit_index;

  function automatic bus_pkg::dev_req_t make_req(input bus_pkg::bus_req_t req,
                                                 input logic [31:0]       offset,
                                                 input logic              hit);
    bus_pkg::dev_req_t dev_req;
    dev_req.offset       = offset;
    dev_req.write_data   = req.write_data;
    dev_req.write_strobe = req.write_strobe;
    dev_req.read_pulse   = req.read_request & hit;
    dev_req.write_pulse  = req.write_request & hit;
    return dev_req;
  endfunction

  // Unsigned offset below the region size means a match
  assign ram_offset    = bus_req_i.address - soc_map_pkg::ram_base;
  assign mtimer_offset = bus_req_i.address - soc_map_pkg::mtimer_base;
  assign gpio_offset   = bus_req_i.address - soc_map_pkg::gpio_base;

  assign ram_hit    = ram_offset < 32'(memory_size);
  assign mtimer_hit = mtimer_offset < 32'(soc_map_pkg::periph_region_size);
  assign gpio_hit   = gpio_offset < 32'(soc_map_pkg::periph_region_size);

  assign ram_req_o    = make_req(bus_req_i, ram_offset, ram_hit);
  assign mtimer_req_o = make_req(bus_req_i, mtimer_offset, mtimer_hit);
  assign gpio_req_o   = make_req(bus_req_i, gpio_offset, gpio_hit);

  // Regions do not overlap, so the order only fixes the encoding
  always_comb begin
    any_hit   = 1'b1;
    hit_index = soc_map_pkg::dev_index_t'(soc_map_pkg::dev_ram);
    if (mtimer_hit) begin
      hit_index = soc_map_pkg::dev_index_t'(soc_map_pkg::dev_mtimer);
    end else if (gpio_hit) begin
      hit_index = soc_map_pkg::dev_index_t'(soc_map_pkg::dev_gpio);
    end else if (!ram_hit) begin
      any_hit = 1'b0;
    end
  end

  // Pending bits follow the pulses; hit and index hold until the next request
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      route_o <= '0;
    end else begin
      route_o.read_pending  <= bus_req_i.read_request;
      route_o.write_pending <= bus_req_i.write_request;
      if (bus_req_i.read_request || bus_req_i.write_request) begin
        route_o.hit       <= any_hit;
        route_o.dev_index <= hit_index;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
/*
  Bus records passed between the address decoder, the devices and
  the response stage, plus the byte-strobe helpers every device uses
  to merge a partial write into a stored word.
*/

`default_nettype none

package bus_pkg;

  // Request from the manager
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  write_strobe;
    logic        read_request;
    logic        write_request;
  } bus_req_t;

  // Request as seen by a single device, address relative to its base
  typedef struct packed {
    logic [31:0] offset;
    logic [31:0] write_data;
    logic [3:0]  write_strobe;
    logic        read_pulse;
    logic        write_pulse;
  } dev_req_t;

  typedef struct packed {
    logic [31:0] read_data;
    logic        read_response;
    logic        write_response;
  } bus_rsp_t;

  // Decoder record of the request one cycle back
  typedef struct packed {
    logic                    read_pending;
    logic                    write_pending;
    logic                    hit;
    soc_map_pkg::dev_index_t dev_index;
  } bus_route_t;

  function automatic logic [31:0] strobe_mask(input logic [3:0] strobe);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{strobe[i]}};
    end
    return mask;
  endfunction

  // Bytes with a strobe take the new data, the rest keep the old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strobe);
    logic [31:0] mask;
    mask = strobe_mask(strobe);
    return (old_word & ~mask) | (new_word & mask);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/bus_result.sv ====
/*
  Result stage of a bus transaction.
  Passes the addressed device's response to the manager. When the
  last request matched no region, it answers on its own with read
  data zero so the manager is never left waiting.
*/

`timescale 1ns/1ps
`default_nettype none

module bus_result (
  input  wire bus_pkg::bus_route_t  route_i,
  input  wire bus_pkg::bus_rsp_t    ram_rsp_i,
  input  wire bus_pkg::bus_rsp_t    mtimer_rsp_i,
  input  wire bus_pkg::bus_rsp_t    gpio_rsp_i,
  output bus_pkg::bus_rsp_t         bus_rsp_o
);

  bus_pkg::bus_rsp_t dev_rsp [soc_map_pkg::num_devices];

  assign dev_rsp[soc_map_pkg::dev_ram]    = ram_rsp_i;
  assign dev_rsp[soc_map_pkg::dev_mtimer] = mtimer_rsp_i;
  assign dev_rsp[soc_map_pkg::dev_gpio]   = gpio_rsp_i;

  always_comb begin
    if (route_i.hit) begin
      bus_rsp_o = dev_rsp[route_i.dev_index];
    end else begin
      // Unmapped access, answer in the same cycle a device would
      bus_rsp_o.read_data      = '0;
      bus_rsp_o.read_response  = route_i.read_pending;
      bus_rsp_o.write_response = route_i.write_pending;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gpio_device.sv ====
/*
  GPIO block on the system bus.
  Output-enable and output registers are read/write; set and clear
  offsets flip only the bits written as one. Pin inputs pass through
  a two-stage synchronizer before they can be read.
*/

`timescale 1ns/1ps
`default_nettype none

module gpio_device #(
  parameter int unsigned gpio_width = 2
) (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::dev_req_t  req_i,
  output bus_pkg::bus_rsp_t       rsp_o,
  input  wire [gpio_width-1:0]    gpio_input_i,
  output logic [gpio_width-1:0]   gpio_oe_o,
  output logic [gpio_width-1:0]   gpio_output_o
);

  localparam soc_map_pkg::periph_offset_t reg_input  = 5'd0;
  localparam soc_map_pkg::periph_offset_t reg_oe     = 5'd4;
  localparam soc_map_pkg::periph_offset_t reg_output = 5'd8;
  localparam soc_map_pkg::periph_offset_t reg_set    = 5'd12;
  localparam soc_map_pkg::periph_offset_t reg_clear  = 5'd16;

  soc_map_pkg::periph_offset_t reg_offset;
  logic [gpio_width-1:0] input_meta;
  logic [gpio_width-1:0] input_sync;
  logic [31:0]           read_value;
  logic [31:0]           write_merge;
  logic [gpio_width-1:0] write_ones;
  logic [31:0]           read_data_q;
  logic                  read_rsp_q;
  logic                  write_rsp_q;

  assign reg_offset = req_i.offset[4:0];

  always_comb begin
    read_value = '0;
    case (reg_offset)
      reg_input:  read_value[gpio_width-1:0] = input_sync;
      reg_oe:     read_value[gpio_width-1:0] = gpio_oe_o;
      reg_output: read_value[gpio_width-1:0] = gpio_output_o;
      default:    read_value = '0;
    endcase
  end

  assign write_merge = bus_pkg::merge_bytes(read_value, req_i.write_data,
                                            req_i.write_strobe);

  // Set and clear act on strobed bytes only
  assign write_ones = gpio_width'(req_i.write_data &
                                  bus_pkg::strobe_mask(req_i.write_strobe));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      input_meta    <= '0;
      input_sync    <= '0;
      gpio_oe_o     <= '0;
      gpio_output_o <= '0;
      read_rsp_q    <= 1'b0;
      write_rsp_q   <= 1'b0;
    end else begin
      input_meta  <= gpio_input_i;
      input_sync  <= input_meta;
      read_rsp_q  <= req_i.read_pulse;
      write_rsp_q <= req_i.write_pulse;
      if (req_i.write_pulse) begin
        case (reg_offset)
          reg_oe:     gpio_oe_o     <= write_merge[gpio_width-1:0];
          reg_output: gpio_output_o <= write_merge[gpio_width-1:0];
          reg_set:    gpio_output_o <= gpio_output_o | write_ones;
          reg_clear:  gpio_output_o <= gpio_output_o & ~write_ones;
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_i.read_pulse) begin
      read_data_q <= read_value;
    end
  end

  assign rsp_o = '{read_data:      read_data_q,
                   read_response:  read_rsp_q,
                   write_response: write_rsp_q};

endmodule

`default_nettype wire

// ==== verilog/mtimer_device.sv ====
/*
  RISC-V machine timer on the system bus.
  A 64-bit mtime counts clocks while bit 0 of the control register is
  set. irq_timer_o is a registered level, high while counting is on
  and mtime has reached mtimecmp. Both 64-bit registers are accessed
  as two 32-bit words.
*/

`timescale 1ns/1ps
`default_nettype none

module mtimer_device (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::dev_req_t  req_i,
  output bus_pkg::bus_rsp_t       rsp_o,
  output logic                    irq_timer_o
);

  localparam soc_map_pkg::periph_offset_t reg_control  = 5'd0;
  localparam soc_map_pkg::periph_offset_t reg_mtime_lo = 5'd4;
  localparam soc_map_pkg::periph_offset_t reg_mtime_hi = 5'd8;
  localparam soc_map_pkg::periph_offset_t reg_cmp_lo   = 5'd12;
  localparam soc_map_pkg::periph_offset_t reg_cmp_hi   = 5'd16;

  soc_map_pkg::periph_offset_t reg_offset;
  logic        count_enable;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] read_value;
  logic [31:0] write_merge;
  logic        write_hit;
  logic [31:0] read_data_q;
  logic        read_rsp_q;
  logic        write_rsp_q;

  assign reg_offset = req_i.offset[4:0];
  assign write_hit  = req_i.write_pulse;

  always_comb begin
    case (reg_offset)
      reg_control:  read_value = {31'b0, count_enable};
      reg_mtime_lo: read_value = mtime[31:0];
      reg_mtime_hi: read_value = mtime[63:32];
      reg_cmp_lo:   read_value = mtimecmp[31:0];
      reg_cmp_hi:   read_value = mtimecmp[63:32];
      default:      read_value = '0;
    endcase
  end

  // Partial writes keep the unstrobed bytes of the addressed word
  assign write_merge = bus_pkg::merge_bytes(read_value, req_i.write_data,
                                            req_i.write_strobe);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count_enable <= 1'b0;
      mtime        <= '0;
      mtimecmp     <= '1;
      irq_timer_o  <= 1'b0;
      read_rsp_q   <= 1'b0;
      write_rsp_q  <= 1'b0;
    end else begin
      read_rsp_q  <= req_i.read_pulse;
      write_rsp_q <= req_i.write_pulse;

      if (write_hit && reg_offset == reg_control) begin
        count_enable <= write_merge[0];
      end

      // A bus write to mtime takes priority over the count
      if (write_hit && reg_offset == reg_mtime_lo) begin
        mtime[31:0] <= write_merge;
      end else if (write_hit && reg_offset == reg_mtime_hi) begin
        mtime[63:32] <= write_merge;
      end else if (count_enable) begin
        mtime <= mtime + 64'd1;
      end

      if (write_hit && reg_offset == reg_cmp_lo) begin
        mtimecmp[31:0] <= write_merge;
      end
      if (write_hit && reg_offset == reg_cmp_hi) begin
        mtimecmp[63:32] <= write_merge;
      end

      irq_timer_o <= count_enable && (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clock) begin
    if (req_i.read_pulse) begin
      read_data_q <= read_value;
    end
  end

  assign rsp_o = '{read_data:      read_data_q,
                   read_response:  read_rsp_q,
                   write_response: write_rsp_q};

endmodule

`default_nettype wire

// ==== verilog/ram_device.sv ====
/*
  Word RAM on the system bus.
  Writes honour the byte strobe and land on the edge ending the
  request cycle. Read data and both response flags appear one cycle
  after the request pulse.
*/

`timescale 1ns/1ps
`default_nettype none

module ram_device #(
  parameter int unsigned memory_size = 8192
) (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::dev_req_t  req_i,
  output bus_pkg::bus_rsp_t       rsp_o
);

  localparam int unsigned num_words = memory_size / 4;
  localparam int unsigned word_bits = $clog2(num_words);

  logic [31:0]          mem [num_words];
  logic [word_bits-1:0] word_index;
  logic [31:0]          read_data_q;
  logic                 read_rsp_q;
  logic                 write_rsp_q;

  // Byte address bits 1:0 select nothing, the strobe covers them
  assign word_index = req_i.offset[word_bits+1:2];

  always_ff @(posedge clock) begin
    if (req_i.write_pulse) begin
      mem[word_index] <= bus_pkg::merge_bytes(mem[word_index], req_i.write_data,
                                              req_i.write_strobe);
    end
    if (req_i.read_pulse) begin
      read_data_q <= mem[word_index];
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_rsp_q  <= 1'b0;
      write_rsp_q <= 1'b0;
    end else begin
      read_rsp_q  <= req_i.read_pulse;
      write_rsp_q <= req_i.write_pulse;
    end
  end

  assign rsp_o = '{read_data:      read_data_q,
                   read_response:  read_rsp_q,
                   write_response: write_rsp_q};

endmodule

`default_nettype wire

// ==== verilog/soc_bus_top.sv ====
/*
  System bus with RAM, machine timer and GPIO.
  The bus manager drives single-cycle read or write pulses on
  bus_req_i and sees the response exactly one cycle later on
  bus_rsp_o, for mapped and unmapped addresses alike.
*/

`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
  // RAM size in bytes, a power of two
  parameter int unsigned memory_size = 8192,
  parameter int unsigned gpio_width  = 2
) (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::bus_req_t  bus_req_i,
  output bus_pkg::bus_rsp_t       bus_rsp_o,
  input  wire [gpio_width-1:0]    gpio_input_i,
  output logic [gpio_width-1:0]   gpio_oe_o,
  output logic [gpio_width-1:0]   gpio_output_o,
  output logic                    irq_timer_o
);

  bus_pkg::dev_req_t   ram_req;
  bus_pkg::dev_req_t   mtimer_req;
  bus_pkg::dev_req_t   gpio_req;
  bus_pkg::bus_rsp_t   ram_rsp;
  bus_pkg::bus_rsp_t   mtimer_rsp;
  bus_pkg::bus_rsp_t   gpio_rsp;
  bus_pkg::bus_route_t route;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------

  bus_decode #(
    .memory_size (memory_size)
  ) u_bus_decode (
    .clock        (clock),
    .reset        (reset),
    .bus_req_i    (bus_req_i),
    .ram_req_o    (ram_req),
    .mtimer_req_o (mtimer_req),
    .gpio_req_o   (gpio_req),
    .route_o      (route)
  );

  // --------------------------------------------------------------------------
  // Devices
  // --------------------------------------------------------------------------

  ram_device #(
    .memory_size (memory_size)
  ) u_ram (
    .clock (clock),
    .reset (reset),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  mtimer_device u_mtimer (
    .clock       (clock),
    .reset       (reset),
    .req_i       (mtimer_req),
    .rsp_o       (mtimer_rsp),
    .irq_timer_o (irq_timer_o)
  );

  gpio_device #(
    .gpio_width (gpio_width)
  ) u_gpio (
    .clock         (clock),
    .reset         (reset),
    .req_i         (gpio_req),
    .rsp_o         (gpio_rsp),
    .gpio_input_i  (gpio_input_i),
    .gpio_oe_o     (gpio_oe_o),
    .gpio_output_o (gpio_output_o)
  );

  // --------------------------------------------------------------------------
  // Result
  // --------------------------------------------------------------------------

  bus_result u_bus_result (
    .route_i      (route),
    .ram_rsp_i    (ram_rsp),
    .mtimer_rsp_i (mtimer_rsp),
    .gpio_rsp_i   (gpio_rsp),
    .bus_rsp_o    (bus_rsp_o)
  );

endmodule

`default_nettype wire

// ==== verilog/soc_map_pkg.sv ====
/*
  Address map of the system bus.
  Holds the device indices, the region base addresses and the region
  size of the peripherals. The RAM region size is the memory_size
  parameter of the top level.
*/

`default_nettype none

package soc_map_pkg;

  // --------------------------------------------------------------------------
  // Device indices
  // --------------------------------------------------------------------------

  localparam int unsigned num_devices = 3;

  localparam int unsigned dev_ram    = 0;
  localparam int unsigned dev_mtimer = 1;
  localparam int unsigned dev_gpio   = 2;

  typedef logic [1:0] dev_index_t;

  // --------------------------------------------------------------------------
  // Region base addresses
  // --------------------------------------------------------------------------

  localparam logic [31:0] ram_base    = 32'h0000_0000;
  localparam logic [31:0] mtimer_base = 32'h8001_0000;
  localparam logic [31:0] gpio_base   = 32'h8002_0000;

  // Timer and GPIO share one region size
  localparam int unsigned periph_region_size = 32;

  // Register offset inside a peripheral region
  typedef logic [4:0] periph_offset_t;

endpackage

`default_nettype wire
